// ==== source/extract_pkg.sv ====
// ======================================
// Extract stage package
// Instruction types, opcodes, field helpers and queue and credit depths
// ======================================
package extract_pkg;

	// ======================================
	// Widths with a meaning
	// ======================================
	typedef logic [31:0] ins_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [4:0]  regno_t;
	typedef logic [15:0] reglist_t;
	typedef logic [3:0]  regidx_t;
	typedef logic [14:0] st_offset_t;
	typedef logic [2:0]  irq_level_t;
	typedef logic [7:0]  irq_vector_t;
	// Wide enough to count up to either depth below
	typedef logic [2:0]  credit_cnt_t;

	// Number of queue entries and of the credits fetch owns after reset
	localparam int QUEUE_DEPTH = 4;
	// Decode credits the extract mux owns after reset
	localparam int OUT_CREDITS = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	typedef logic [QPTR_W-1:0] qptr_t;

	// Opcodes live in bits 6..0 of every word
	localparam opcode_t OP_NOP = 7'd0;
	localparam opcode_t OP_ST  = 7'd35;
	localparam opcode_t OP_STM = 7'd39;
	localparam opcode_t OP_CHK = 7'd115;
	// The nop word is all zeros
	localparam ins_t NOP_WORD = {25'd0, OP_NOP};

	function automatic opcode_t opcode_of(input ins_t ins);
		return ins[6:0];
	endfunction

	// STM holds its base register in bits 11..7 and the mask in bits 31..16
	function automatic regno_t stm_base(input ins_t ins);
		return ins[11:7];
	endfunction

	function automatic reglist_t stm_mask(input ins_t ins);
		return ins[31:16];
	endfunction

	// ST is offset in 31..17, base in 16..12 and data register in 11..7.
	// The k-th set bit of an STM mask, counted from 0 in ascending register order,
	// becomes an ST with data register equal to the bit index,
	// base equal to the STM base and offset equal to 8 times k
	function automatic ins_t make_st(input regno_t data, input regno_t base,
		input st_offset_t offset);
		return {offset, base, data, OP_ST};
	endfunction

	// CHK carries the vector in 31..24 and the level in 16..14, all else zero
	function automatic ins_t make_chk(input irq_level_t level, input irq_vector_t vector);
		return {vector, 7'd0, level, 7'd0, OP_CHK};
	endfunction

endpackage

// ==== source/uop_if.sv ====
// ======================================
// Micro-op link
// Carries expanded or passed-through words from the expander to the mux
// ======================================
`timescale 1ns/1ps

interface uop_if
	import extract_pkg::*;
	();

	// A word is on offer this cycle
	logic uop_valid;
	// The offered word is never an STM
	ins_t uop_ins;
	// High while a store-multiple is being unrolled
	logic reglist_active;
	// The mux registers the offered word on this cycle's edge
	logic uop_take;

	// An item is consumed when uop_valid and uop_take are both high
	modport expander_mp (
		output uop_valid,
		output uop_ins,
		output reglist_active,
		input  uop_take
	);

	modport mux_mp (
		input  uop_valid,
		input  uop_ins,
		input  reglist_active,
		output uop_take
	);

endinterface

// ==== source/ins_queue.sv ====
// ======================================
// Instruction queue
// Credit-controlled circular FIFO between fetch and the expander
// ======================================
`timescale 1ns/1ps

module ins_queue
	import extract_pkg::*;
	(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  ins_t in_ins,
	output logic in_credit,
	output logic head_valid,
	output ins_t head_ins,
	input  logic head_pop
);

	// The count says which entries hold live words
	ins_t mem [QUEUE_DEPTH];
	qptr_t wr_ptr;
	qptr_t rd_ptr;
	credit_cnt_t count;

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (head_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + credit_cnt_t'(in_valid) - credit_cnt_t'(head_pop);
			// Every pop frees a slot, so one credit goes back upstream
			in_credit <= head_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in_ins;
	end

	// A word written at an edge is visible at the head right after it
	assign head_valid = (count != '0);
	assign head_ins = mem[rd_ptr];

	// ======================================
	// Protocol checks
	// ======================================

	// Fetch only writes while holding a credit, so a full queue never sees a write
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> (count != credit_cnt_t'(QUEUE_DEPTH)));

	// The expander only pops what is actually at the head
	a_no_underrun: assert property (@(posedge clk) disable iff (rst)
		head_pop |-> head_valid);

endmodule

// ==== source/reglist_expander.sv ====
// ======================================
// Register-list expander
// Unrolls STM into one ST per mask bit and passes other words through
// ======================================
`timescale 1ns/1ps

module reglist_expander
	import extract_pkg::*;
	(
	input  logic clk,
	input  logic rst,
	input  logic head_valid,
	input  ins_t head_ins,
	output logic head_pop,
	uop_if.expander_mp uop
);

	typedef enum logic {
		EXP_IDLE,
		EXP_EXPANDING
	} exp_state_t;

	exp_state_t state;
	regno_t base_q;
	reglist_t mask_q;
	// Slot k of the expansion sets the store offset
	regidx_t slot_q;
	regidx_t low_idx;
	logic head_is_stm;

	assign head_is_stm = head_valid && (opcode_of(head_ins) == OP_STM);

	// Pick the lowest remaining register of the mask
	always_comb begin
		low_idx = '0;
		for (int i = 15; i >= 0; i--) begin
			if (mask_q[i])
				low_idx = regidx_t'(i);
		end
	end

	// Plain words pass straight through and an STM is swallowed on its first head cycle
	always_comb begin
		if (state == EXP_EXPANDING) begin
			uop.uop_valid = 1'b1;
			uop.uop_ins = make_st({1'b0, low_idx}, base_q, {8'd0, slot_q, 3'd0});
			head_pop = 1'b0;
		end else begin
			uop.uop_valid = head_valid && !head_is_stm;
			uop.uop_ins = head_ins;
			head_pop = head_is_stm || (uop.uop_valid && uop.uop_take);
		end
	end

	assign uop.reglist_active = (state == EXP_EXPANDING);

	// Next state of the expansion
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= EXP_IDLE;
		end else if (state == EXP_IDLE) begin
			// An empty mask leaves nothing to issue
			if (head_is_stm && (stm_mask(head_ins) != '0))
				state <= EXP_EXPANDING;
		end else if (uop.uop_take) begin
			// The store just taken was the last one when one bit was left
			if ((mask_q & (mask_q - 1'b1)) == '0)
				state <= EXP_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (state == EXP_IDLE && head_is_stm) begin
			base_q <= stm_base(head_ins);
			mask_q <= stm_mask(head_ins);
			slot_q <= '0;
		end else if (state == EXP_EXPANDING && uop.uop_take) begin
			mask_q[low_idx] <= 1'b0;
			slot_q <= slot_q + 1'b1;
		end
	end

	// A macro instruction never leaks to the mux unexpanded
	a_no_stm_out: assert property (@(posedge clk) disable iff (rst)
		uop.uop_valid |-> (opcode_of(uop.uop_ins) != OP_STM));

endmodule

// ==== source/irq_injector.sv ====
// ======================================
// Interrupt injector
// Masks hardware requests and holds one pending for the mux
// ======================================
`timescale 1ns/1ps

module irq_injector
	import extract_pkg::*;
	(
	input  logic clk,
	input  logic rst,
	input  logic irq_req,
	input  irq_level_t irq_level,
	input  irq_vector_t irq_vector,
	input  irq_level_t irq_mask,
	input  logic reglist_active,
	input  logic hirq_taken,
	output logic hirq,
	output irq_level_t pend_level,
	output irq_vector_t pend_vector
);

	logic pending;
	logic accept;

	// Only a level strictly above the mask is taken, and only while idle
	assign accept = irq_req && !pending && (irq_level > irq_mask);

	always_ff @(posedge clk) begin
		if (rst)
			pending <= 1'b0;
		else if (accept)
			pending <= 1'b1;
		else if (hirq_taken)
			pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pend_level <= irq_level;
			pend_vector <= irq_vector;
		end
	end

	// Hold the request back until a store-multiple has fully unrolled
	assign hirq = pending && !reglist_active;

endmodule

// ==== source/ins_extract_mux.sv ====
// ======================================
// Extract mux
// Registers interrupt check, micro-op or nop toward decode under credits
// ======================================
`timescale 1ns/1ps

module ins_extract_mux
	import extract_pkg::*;
	(
	input  logic clk,
	input  logic rst,
	input  logic hirq,
	input  irq_level_t pend_level,
	input  irq_vector_t pend_vector,
	output logic hirq_taken,
	uop_if.mux_mp uop,
	input  logic out_credit,
	output logic out_valid,
	output ins_t out_ins
);

	credit_cnt_t credits;
	logic grant;
	logic issue;

	// Nothing moves while decode has no room
	assign grant = (credits != '0);
	assign hirq_taken = grant && hirq;
	// The interrupt wins over the micro-op stream
	assign uop.uop_take = grant && !hirq;
	assign issue = grant && (hirq || uop.uop_valid);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_ins <= NOP_WORD;
			credits <= credit_cnt_t'(OUT_CREDITS);
		end else begin
			if (grant && hirq) begin
				out_valid <= 1'b1;
				out_ins <= make_chk(pend_level, pend_vector);
			end else if (grant && uop.uop_valid) begin
				out_valid <= 1'b1;
				out_ins <= uop.uop_ins;
			end else begin
				out_valid <= 1'b0;
				out_ins <= NOP_WORD;
			end
			// One credit spent per issue, one back per decode pulse
			credits <= credits + credit_cnt_t'(out_credit) - credit_cnt_t'(issue);
		end
	end

	// Decode never returns more credits than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= credit_cnt_t'(OUT_CREDITS));

endmodule

// ==== source/ins_extract_top.sv ====
// ======================================
// Instruction extract stage top level
// Joins queue, expander, interrupt injector and extract mux
// ======================================
`timescale 1ns/1ps

module ins_extract_top
	import extract_pkg::*;
	(
	input  logic clk,
	input  logic rst,
	// Fetch side
	input  logic in_valid,
	input  ins_t in_ins,
	output logic in_credit,
	// Interrupt side
	input  logic irq_req,
	input  irq_level_t irq_level,
	input  irq_vector_t irq_vector,
	input  irq_level_t irq_mask,
	// Decode side
	output logic out_valid,
	output ins_t out_ins,
	input  logic out_credit
);

	logic head_valid;
	ins_t head_ins;
	logic head_pop;
	logic hirq;
	logic hirq_taken;
	irq_level_t pend_level;
	irq_vector_t pend_vector;

	uop_if uop_bus ();

	// ======================================
	// Datapath from fetch to decode
	// ======================================
	ins_queue queue_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_ins     (in_ins),
		.in_credit  (in_credit),
		.head_valid (head_valid),
		.head_ins   (head_ins),
		.head_pop   (head_pop)
	);

	reglist_expander expander_i (
		.clk        (clk),
		.rst        (rst),
		.head_valid (head_valid),
		.head_ins   (head_ins),
		.head_pop   (head_pop),
		.uop        (uop_bus.expander_mp)
	);

	// The injector sees the expansion flag so a check never splits an STM
	irq_injector injector_i (
		.clk            (clk),
		.rst            (rst),
		.irq_req        (irq_req),
		.irq_level      (irq_level),
		.irq_vector     (irq_vector),
		.irq_mask       (irq_mask),
		.reglist_active (uop_bus.reglist_active),
		.hirq_taken     (hirq_taken),
		.hirq           (hirq),
		.pend_level     (pend_level),
		.pend_vector    (pend_vector)
	);

	ins_extract_mux mux_i (
		.clk         (clk),
		.rst         (rst),
		.hirq        (hirq),
		.pend_level  (pend_level),
		.pend_vector (pend_vector),
		.hirq_taken  (hirq_taken),
		.uop         (uop_bus.mux_mp),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_ins     (out_ins)
	);

endmodule

// ==== testbench/tb_ins_extract.sv ====
// ======================================
// Extract stage testbench
// Directed tests with a credit-tracking fetch driver and a checking decode sink
// ======================================
`timescale 1ns/1ps

module tb_ins_extract
	import extract_pkg::*;
	();

	// About 40 cycles for each of the roughly 75 expected words plus a margin
	localparam int TIMEOUT_CYCLES = 40 * 75 + 200;

	logic clk;
	logic rst;
	logic in_valid;
	ins_t in_ins;
	logic in_credit;
	logic irq_req;
	irq_level_t irq_level;
	irq_vector_t irq_vector;
	irq_level_t irq_mask;
	logic out_valid;
	ins_t out_ins;
	logic out_credit = 1'b0;

	// Sink holds back decode credits while this is high
	logic hold = 1'b0;
	ins_t exp_q[$];
	// Cycle at which each outstanding decode credit goes back
	int owed[$];
	int cycle = 0;
	int returned = 0;
	int sent;
	int received;

	ins_extract_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_ins     (in_ins),
		.in_credit  (in_credit),
		.irq_req    (irq_req),
		.irq_level  (irq_level),
		.irq_vector (irq_vector),
		.irq_mask   (irq_mask),
		.out_valid  (out_valid),
		.out_ins    (out_ins),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================
	// Reporting
	// ======================================
	task automatic end_in_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
			end_in_failure();
		end
	endtask

	// ======================================
	// Reference words built from the field layout
	// ======================================
	function automatic ins_t st_word(input regno_t data, input regno_t base,
		input st_offset_t offset);
		ins_t w;
		w = '0;
		w[31:17] = offset;
		w[16:12] = base;
		w[11:7] = data;
		w[6:0] = OP_ST;
		return w;
	endfunction

	function automatic ins_t stm_word(input regno_t base, input reglist_t mask);
		ins_t w;
		w = '0;
		w[31:16] = mask;
		w[11:7] = base;
		w[6:0] = OP_STM;
		return w;
	endfunction

	function automatic ins_t chk_word(input irq_level_t level, input irq_vector_t vector);
		ins_t w;
		w = '0;
		w[31:24] = vector;
		w[16:14] = level;
		w[6:0] = OP_CHK;
		return w;
	endfunction

	// Slot k of the expansion stores register i at offset 8*k
	task automatic expect_stores(input regno_t base, input reglist_t mask);
		int k;
		k = 0;
		for (int i = 0; i < 16; i++) begin
			if (mask[i]) begin
				exp_q.push_back(st_word(regno_t'(i), base, st_offset_t'(8 * k)));
				k++;
			end
		end
	endtask

	// ======================================
	// Fetch driver, decode sink and timeout
	// ======================================

	// Returned credits show up here a cycle after the DUT frees the slot
	task automatic send_word(input ins_t w);
		@(posedge clk);
		while (QUEUE_DEPTH + returned - sent == 0) begin
			in_valid <= 1'b0;
			@(posedge clk);
		end
		in_valid <= 1'b1;
		in_ins <= w;
		sent++;
	endtask

	task automatic end_burst();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// Let late decode credits come home before the next test
	task automatic wait_drained();
		@(negedge clk);
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (8) @(negedge clk);
	endtask

	always @(posedge clk) begin
		if (out_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR: out_valid rose with no word expected, out_ins 0x%08h", out_ins);
				end_in_failure();
			end
			check_value("out_ins", out_ins, exp_q.pop_front());
			received++;
			owed.push_back(cycle + int'($urandom_range(0, 3)));
		end else if (!rst) begin
			// Between issues decode sees the all-zero nop word
			check_value("out_ins", out_ins, 32'h0);
		end
		if (owed.size() > OUT_CREDITS) begin
			$display("ERROR: more words issued than decode credits allow");
			end_in_failure();
		end
		if (!hold && owed.size() != 0 && owed[0] <= cycle) begin
			out_credit <= 1'b1;
			void'(owed.pop_front());
		end else begin
			out_credit <= 1'b0;
		end
		if (in_credit)
			returned <= returned + 1;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("ERROR: timed out after %0d cycles waiting for the DUT", cycle);
			end_in_failure();
		end
	end

	// ======================================
	// Directed tests
	// ======================================
	task automatic plain_passthrough();
		ins_t w;
		for (int i = 0; i < 20; i++) begin
			w = $urandom;
			w[6:0] = OP_ST;
			exp_q.push_back(w);
			send_word(w);
		end
		end_burst();
		wait_drained();
	endtask

	task automatic stm_expansion();
		reglist_t masks [3];
		regno_t base;
		ins_t w;
		masks = '{16'h0001, 16'h8421, 16'hFFFF};
		for (int i = 0; i < 3; i++) begin
			base = regno_t'($urandom_range(0, 31));
			expect_stores(base, masks[i]);
			send_word(stm_word(base, masks[i]));
		end
		// An empty mask vanishes and the next word follows at once
		send_word(stm_word(5'd3, 16'h0000));
		w = st_word(5'd9, 5'd4, 15'h0123);
		exp_q.push_back(w);
		send_word(w);
		end_burst();
		wait_drained();
	endtask

	task automatic irq_injection();
		ins_t w;
		exp_q.push_back(chk_word(3'd5, 8'h5a));
		for (int i = 0; i < 3; i++) begin
			w = st_word(regno_t'(i), 5'd1, st_offset_t'(i));
			exp_q.push_back(w);
			send_word(w);
			// The request rides with the first word so both reach the mux together
			if (i == 0) begin
				irq_req <= 1'b1;
				irq_level <= 3'd5;
				irq_vector <= 8'h5a;
			end else if (i == 1) begin
				// Second request lands while the first is still pending
				irq_level <= 3'd6;
				irq_vector <= 8'hc3;
			end else begin
				irq_req <= 1'b0;
			end
		end
		end_burst();
		wait_drained();
		// Level equal to the mask is not above it
		@(posedge clk);
		irq_req <= 1'b1;
		irq_level <= 3'd3;
		irq_vector <= 8'h77;
		@(posedge clk);
		irq_req <= 1'b0;
		w = st_word(5'd20, 5'd21, 15'h0040);
		exp_q.push_back(w);
		send_word(w);
		end_burst();
		wait_drained();
	endtask

	task automatic irq_after_expansion();
		ins_t w;
		expect_stores(5'd2, 16'hFFFF);
		send_word(stm_word(5'd2, 16'hFFFF));
		end_burst();
		// The STM is already unrolling when this request is captured
		@(posedge clk);
		irq_req <= 1'b1;
		irq_level <= 3'd7;
		irq_vector <= 8'h81;
		exp_q.push_back(chk_word(3'd7, 8'h81));
		@(posedge clk);
		irq_req <= 1'b0;
		w = st_word(5'd30, 5'd31, 15'h7ff8);
		exp_q.push_back(w);
		send_word(w);
		end_burst();
		wait_drained();
	endtask

	task automatic credit_backpressure();
		ins_t words [10];
		int sent_before;
		int got_before;
		for (int i = 0; i < 10; i++) begin
			words[i] = $urandom;
			words[i][6:0] = OP_ST;
		end
		sent_before = sent;
		got_before = received;
		@(posedge clk);
		hold <= 1'b1;
		fork
			begin
				for (int i = 0; i < 10; i++) begin
					exp_q.push_back(words[i]);
					send_word(words[i]);
				end
				end_burst();
			end
			begin
				repeat (40) @(posedge clk);
				@(negedge clk);
				// Mux spends its credits, then the queue fills and fetch stalls
				check_value("out_valid count", received - got_before, OUT_CREDITS);
				check_value("in_valid count", sent - sent_before, QUEUE_DEPTH + OUT_CREDITS);
				@(posedge clk);
				hold <= 1'b0;
			end
		join
		wait_drained();
		check_value("in_credit count", returned, sent);
	endtask

	initial begin
		void'($urandom(32'h80675554));
		rst <= 1'b1;
		in_valid <= 1'b0;
		in_ins <= '0;
		irq_req <= 1'b0;
		irq_level <= '0;
		irq_vector <= '0;
		irq_mask <= 3'd3;
		sent = 0;
		received = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		plain_passthrough();
		stm_expansion();
		irq_injection();
		irq_after_expansion();
		credit_backpressure();
		@(negedge clk);
		if (exp_q.size() == 0 && returned == sent) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("ERROR: words still expected or fetch credits unbalanced at the end");
			end_in_failure();
		end
	end

endmodule

// ==== compile.f ====
source/extract_pkg.sv
source/uop_if.sv
source/ins_queue.sv
source/reglist_expander.sv
source/irq_injector.sv
source/ins_extract_mux.sv
source/ins_extract_top.sv
testbench/tb_ins_extract.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the extract stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_ins_extract -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_ins_extract)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1
